// ==== alu_exe.sv ====
`timescale 1ns/10ps
`include "mips16_slice_settings.svh"

module alu_exe (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    hold,
	input  mips16_slice_pkg::exe_t  exe,
	output mips16_slice_pkg::word_t result,
	output mips16_slice_pkg::wb_t   wb
);
	import mips16_slice_pkg::*;

	logic [3:0] sh;  // Shift amounts stay below 16

	assign sh = exe.op2[3:0];

	//////////////////////////////////////////////////
	// ALU
	//////////////////////////////////////////////////
	always_comb begin
		case (exe.alu_op)
			ADD:  result = exe.op1 + exe.op2;
			SUB:  result = exe.op1 - exe.op2;
			AND:  result = exe.op1 & exe.op2;
			OR:   result = exe.op1 | exe.op2;
			CMP:  result = (exe.op1 == exe.op2) ? '0 : word_t'(1);  // Zero when equal
			SLL:  result = exe.op1 << sh;
			SRL:  result = exe.op1 >> sh;
			SRA,
			SRAV: result = word_t'($signed(exe.op1) >>> sh);
			PASS: result = exe.op1;
			default: result = exe.op1;
		endcase
	end

	//////////////////////////////////////////////////
	// Retire register
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			wb.valid <= 1'b0;
			wb.dst   <= `REG_NONE;
		end else if (!hold) begin
			wb.valid <= exe.valid;
			wb.dst   <= exe.dst;
			wb.value <= result;  // Also feeds the register file
		end
	end

endmodule

// ==== id_exe.sv ====
`timescale 1ns/10ps
`include "mips16_slice_settings.svh"

module id_exe (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     hold,
	input  logic                     flush,
	input  mips16_slice_pkg::dec_t   dec,
	input  mips16_slice_pkg::word_t  read_value1,
	input  mips16_slice_pkg::word_t  read_value2,
	output mips16_slice_pkg::exe_t   exe
);
	import mips16_slice_pkg::*;

	word_t    op1_nxt;
	word_t    op2_nxt;
	word_t    simm8;
	word_t    simm4;
	word_t    zimm8;
	word_t    shamt;
	logic [2:0] amt;

	//////////////////////////////////////////////////
	// Immediate forms
	//////////////////////////////////////////////////
	assign simm8 = {{(`DATA_W-8){dec.instr[7]}}, dec.instr[7:0]};
	assign simm4 = {{(`DATA_W-4){dec.instr[3]}}, dec.instr[3:0]};
	assign zimm8 = {{(`DATA_W-8){1'b0}}, dec.instr[7:0]};
	assign amt   = dec.instr[4:2];
	assign shamt = (amt == 3'd0) ? word_t'(8) : {{(`DATA_W-3){1'b0}}, amt};  // 0 shifts by 8

	//////////////////////////////////////////////////
	// Operand selection
	//////////////////////////////////////////////////
	always_comb begin
		op1_nxt = read_value1;  // Register forms by default
		op2_nxt = read_value2;
		case (dec.instr[15:11])
			5'b01001: op2_nxt = simm8;  // ADDIU
			5'b01000: op2_nxt = simm4;  // ADDIU3
			5'b01100: begin
				if (dec.instr[10:8] == 3'b011) begin  // ADDSP
					op2_nxt = simm8;
				end else begin                        // MTSP
					op2_nxt = '0;
				end
			end
			5'b01101: begin  // LI
				op1_nxt = zimm8;
				op2_nxt = '0;
			end
			5'b01111: begin  // MOVE
				op1_nxt = read_value2;
				op2_nxt = '0;
			end
			5'b11101: begin
				if (dec.instr[7:0] == 8'h40) begin  // MFPC
					op1_nxt = dec.pc + 1'b1;
					op2_nxt = '0;
				end
			end
			5'b11110: op2_nxt = '0;  // MFIH, MTIH
			5'b00110: begin          // SLL, SRL, SRA
				op1_nxt = read_value2;
				op2_nxt = shamt;
			end
			default: begin
				op1_nxt = read_value1;
				op2_nxt = read_value2;
			end
		endcase
	end

	//////////////////////////////////////////////////
	// Stage register
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			exe.valid  <= 1'b0;
			exe.dst    <= `REG_NONE;
			exe.alu_op <= PASS;
		end else if (flush) begin
			exe.valid  <= 1'b0;  // Bubble even while held
			exe.dst    <= `REG_NONE;
			exe.alu_op <= PASS;
		end else if (!hold) begin
			exe.valid  <= dec.valid;
			exe.dst    <= dec.dst;
			exe.alu_op <= dec.alu_op;
			exe.op1    <= op1_nxt;
			exe.op2    <= op2_nxt;
		end
	end

endmodule

// ==== instr_decode.sv ====
`timescale 1ns/10ps
`include "mips16_slice_settings.svh"

module instr_decode (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        hold,
	input  mips16_slice_pkg::instr_in_t in,
	output mips16_slice_pkg::dec_t      dec
);
	import mips16_slice_pkg::*;

	dec_t      nxt;
	logic      known;
	reg_addr_t rx;
	reg_addr_t ry;
	reg_addr_t rz;

	assign rx = {1'b0, in.instr[10:8]};
	assign ry = {1'b0, in.instr[7:5]};
	assign rz = {1'b0, in.instr[4:2]};

	//////////////////////////////////////////////////
	// Opcode decode
	//////////////////////////////////////////////////
	always_comb begin
		nxt        = '0;
		nxt.instr  = in.instr;
		nxt.pc     = in.pc;
		nxt.src1   = `REG_NONE;
		nxt.src2   = `REG_NONE;
		nxt.dst    = `REG_NONE;
		nxt.alu_op = PASS;
		known      = 1'b1;
		case (in.instr[15:11])
			5'b01001: begin  // ADDIU
				nxt.src1   = rx;
				nxt.dst    = rx;
				nxt.alu_op = ADD;
			end
			5'b01000: begin  // ADDIU3
				nxt.src1   = rx;
				nxt.dst    = ry;
				nxt.alu_op = ADD;
			end
			5'b01100: begin
				if (in.instr[10:8] == 3'b011) begin  // ADDSP
					nxt.src1   = `REG_SP;
					nxt.dst    = `REG_SP;
					nxt.alu_op = ADD;
				end else if (in.instr[10:8] == 3'b100 && in.instr[4:0] == 5'b00000) begin
					nxt.src1 = ry;  // MTSP
					nxt.dst  = `REG_SP;
				end else begin
					known = 1'b0;
				end
			end
			5'b01101: nxt.dst = rx;  // LI
			5'b01111: begin
				if (in.instr[4:0] == 5'b00000) begin  // MOVE
					nxt.src2 = ry;
					nxt.dst  = rx;
				end else begin
					known = 1'b0;
				end
			end
			5'b11100: begin
				nxt.src1 = rx;
				nxt.src2 = ry;
				nxt.dst  = rz;
				if (in.instr[1:0] == 2'b01) nxt.alu_op = ADD;       // ADDU
				else if (in.instr[1:0] == 2'b11) nxt.alu_op = SUB;  // SUBU
				else known = 1'b0;
			end
			5'b11101: begin
				nxt.src1 = rx;
				nxt.src2 = ry;
				nxt.dst  = rx;
				case (in.instr[4:0])
					5'b01100: nxt.alu_op = AND;
					5'b01101: nxt.alu_op = OR;
					5'b01010: begin
						nxt.alu_op = CMP;
						nxt.dst    = `REG_T;
					end
					5'b00111: begin  // SRAV ry <- ry >> rx
						nxt.src1   = ry;
						nxt.src2   = rx;
						nxt.dst    = ry;
						nxt.alu_op = SRAV;
					end
					5'b00000: begin  // MFPC, JR and JALR share this code
						nxt.src1 = `REG_NONE;
						nxt.src2 = `REG_NONE;
						known    = (in.instr[7:0] == 8'h40);
					end
					default: known = 1'b0;
				endcase
			end
			5'b11110: begin
				if (in.instr[7:0] == 8'h00) begin  // MFIH
					nxt.src1 = `REG_IH;
					nxt.dst  = rx;
				end else if (in.instr[7:0] == 8'h01) begin  // MTIH
					nxt.src1 = rx;
					nxt.dst  = `REG_IH;
				end else begin
					known = 1'b0;
				end
			end
			5'b00110: begin
				nxt.src2 = ry;
				nxt.dst  = rx;
				if (in.instr[1:0] == 2'b00) nxt.alu_op = SLL;
				else if (in.instr[1:0] == 2'b10) nxt.alu_op = SRL;
				else if (in.instr[1:0] == 2'b11) nxt.alu_op = SRA;
				else known = 1'b0;
			end
			default: known = 1'b0;  // NOP and the rest retire as bubbles
		endcase
		nxt.valid = in.valid && known;
		if (!nxt.valid) begin
			nxt.src1 = `REG_NONE;
			nxt.src2 = `REG_NONE;
			nxt.dst  = `REG_NONE;
		end
	end

	//////////////////////////////////////////////////
	// Decode register
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			dec.valid <= 1'b0;
			dec.src1  <= `REG_NONE;
			dec.src2  <= `REG_NONE;
			dec.dst   <= `REG_NONE;
		end else if (!hold) begin
			dec <= nxt;
		end
	end

endmodule

// ==== mips16_slice.f ====
+incdir+.
mips16_slice_pkg.sv
reg_file.sv
instr_decode.sv
operand_fwd.sv
id_exe.sv
alu_exe.sv
mips16_slice_top.sv
tb_mips16_slice.sv

// ==== mips16_slice_pkg.sv ====
`include "mips16_slice_settings.svh"

package mips16_slice_pkg;

	typedef logic [`DATA_W-1:0]     word_t;
	typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

	typedef enum logic [3:0] {
		ADD,
		SUB,
		AND,
		OR,
		CMP,   // T = (op1 != op2)
		SLL,
		SRL,
		SRA,
		SRAV,  // op1 >>> op2[3:0]
		PASS   // Result is op1
	} alu_op_e;

	typedef struct packed {
		logic  valid;
		word_t instr;
		word_t pc;
	} instr_in_t;

	typedef struct packed {
		logic      valid;
		word_t     instr;
		word_t     pc;
		reg_addr_t src1;  // Read through port 1
		reg_addr_t src2;  // Read through port 2
		reg_addr_t dst;
		alu_op_e   alu_op;
	} dec_t;

	typedef struct packed {
		logic      valid;
		reg_addr_t dst;
		alu_op_e   alu_op;
		word_t     op1;
		word_t     op2;
	} exe_t;

	typedef struct packed {
		logic      valid;
		reg_addr_t dst;
		word_t     value;
	} wb_t;

endpackage

// ==== mips16_slice_settings.svh ====
`ifndef MIPS16_SLICE_SETTINGS_SVH
`define MIPS16_SLICE_SETTINGS_SVH

//////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////
`define DATA_W      16  // Register and data width
`define REG_CNT     11  // R0-R7, SP, IH, T
`define REG_ADDR_W  4   // Register index width

//////////////////////////////////////////////////
// Fixed register indices
//////////////////////////////////////////////////
`define REG_SP      4'd8
`define REG_IH      4'd9
`define REG_T       4'd10
`define REG_NONE    4'd15  // Bubble or unused source

`endif

// ==== mips16_slice_top.sv ====
`timescale 1ns/10ps
`include "mips16_slice_settings.svh"

module mips16_slice_top (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        hold,
	input  logic                        flush,
	input  mips16_slice_pkg::instr_in_t in,
	output mips16_slice_pkg::wb_t       wb
);
	import mips16_slice_pkg::*;

	dec_t  dec;
	exe_t  exe;
	word_t rf_data1;
	word_t rf_data2;
	word_t fwd1;
	word_t fwd2;
	word_t result;

	//////////////////////////////////////////////////
	// Decode and operand read
	//////////////////////////////////////////////////
	instr_decode u_decode (
		.clk  (clk),
		.rst  (rst),
		.hold (hold),
		.in   (in),
		.dec  (dec)
	);

	reg_file u_regs (
		.clk      (clk),
		.rst      (rst),
		.rd_addr1 (dec.src1),
		.rd_addr2 (dec.src2),
		.rd_data1 (rf_data1),
		.rd_data2 (rf_data2),
		.wb       (wb)
	);

	operand_fwd u_fwd (
		.src1       (dec.src1),
		.src2       (dec.src2),
		.rf_data1   (rf_data1),
		.rf_data2   (rf_data2),
		.exe_dst    (exe.dst),
		.exe_result (result),
		.exe_valid  (exe.valid),
		.wb         (wb),
		.fwd1       (fwd1),
		.fwd2       (fwd2)
	);

	//////////////////////////////////////////////////
	// Operand stage and execute
	//////////////////////////////////////////////////
	id_exe u_id_exe (
		.clk         (clk),
		.rst         (rst),
		.hold        (hold),
		.flush       (flush),
		.dec         (dec),
		.read_value1 (fwd1),
		.read_value2 (fwd2),
		.exe         (exe)
	);

	alu_exe u_alu (
		.clk    (clk),
		.rst    (rst),
		.hold   (hold),
		.exe    (exe),
		.result (result),
		.wb     (wb)
	);

endmodule

// ==== operand_fwd.sv ====
`timescale 1ns/10ps
`include "mips16_slice_settings.svh"

module operand_fwd (
	input  mips16_slice_pkg::reg_addr_t src1,
	input  mips16_slice_pkg::reg_addr_t src2,
	input  mips16_slice_pkg::word_t     rf_data1,
	input  mips16_slice_pkg::word_t     rf_data2,
	input  mips16_slice_pkg::reg_addr_t exe_dst,
	input  mips16_slice_pkg::word_t     exe_result,
	input  logic                        exe_valid,
	input  mips16_slice_pkg::wb_t       wb,
	output mips16_slice_pkg::word_t     fwd1,
	output mips16_slice_pkg::word_t     fwd2
);
	import mips16_slice_pkg::*;

	// Youngest producer wins
	function automatic word_t pick(input reg_addr_t src, input word_t rf_val,
			input logic x_valid, input reg_addr_t x_dst, input word_t x_result,
			input wb_t w);
		word_t value;
		value = rf_val;
		if (src != `REG_NONE) begin
			if (x_valid && (x_dst == src)) begin
				value = x_result;  // Still in the ALU
			end else if (w.valid && (w.dst == src)) begin
				value = w.value;   // Not yet in the register file
			end
		end
		return value;
	endfunction

	always_comb begin
		fwd1 = pick(src1, rf_data1, exe_valid, exe_dst, exe_result, wb);
		fwd2 = pick(src2, rf_data2, exe_valid, exe_dst, exe_result, wb);
	end

endmodule

// ==== reg_file.sv ====
`timescale 1ns/10ps
`include "mips16_slice_settings.svh"

module reg_file (
	input  logic                        clk,
	input  logic                        rst,
	input  mips16_slice_pkg::reg_addr_t rd_addr1,
	input  mips16_slice_pkg::reg_addr_t rd_addr2,
	output mips16_slice_pkg::word_t     rd_data1,
	output mips16_slice_pkg::word_t     rd_data2,
	input  mips16_slice_pkg::wb_t       wb
);
	import mips16_slice_pkg::*;

	word_t regs [`REG_CNT];  // R0-R7, SP, IH, T

	// Addresses past the last register read as zero
	function automatic word_t read_port(input reg_addr_t addr);
		word_t value;
		value = '0;
		if (addr < `REG_CNT) begin
			value = regs[addr];
		end
		return value;
	endfunction

	//////////////////////////////////////////////////
	// Write port
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `REG_CNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.valid && (wb.dst < `REG_CNT)) begin
			regs[wb.dst] <= wb.value;  // End of write-back cycle
		end
	end

	//////////////////////////////////////////////////
	// Read ports
	//////////////////////////////////////////////////
	always_comb begin
		rd_data1 = read_port(rd_addr1);
		rd_data2 = read_port(rd_addr2);
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module tb_mips16_slice --Mdir obj_dir -f mips16_slice.f

output=$(./obj_dir/Vtb_mips16_slice 2>&1) || true
echo "$output"

if echo "$output" | grep -qF "=== PASS ==="; then
	exit 0
fi
exit 1

// ==== tb_mips16_slice.sv ====
`timescale 1ns/10ps
`include "mips16_slice_settings.svh"

module tb_mips16_slice;
	import mips16_slice_pkg::*;

	logic      clk;
	logic      rst;
	logic      hold;
	logic      flush;
	instr_in_t in;
	wb_t       wb;

	word_t       shadow [`REG_CNT];  // Expected architectural state
	wb_t         exp_q [$];
	int          due_q [$];          // Non-hold edge count at which each record shows
	logic [31:0] seed = 32'h6a0a_ab2f;
	word_t       pc = 16'h0100;
	int          adv_edges = 0;
	string       test_name = "reset";

	mips16_slice_top UUT (
		.clk   (clk),
		.rst   (rst),
		.hold  (hold),
		.flush (flush),
		.in    (in),
		.wb    (wb)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		if (!hold) adv_edges <= adv_edges + 1;  // Only these edges move the pipeline
	end

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	//////////////////////////////////////////////////
	// Stimulus generation
	//////////////////////////////////////////////////
	function automatic word_t make_instr(input int kind);
		logic [31:0] r;
		logic [2:0]  a;
		logic [2:0]  b;
		logic [2:0]  c;
		logic [7:0]  imm;
		word_t       ins;
		r   = lcg_next();
		a   = r[31:29];
		b   = r[28:26];
		c   = r[25:23];
		imm = r[22:15];
		case (kind)
			0:  ins = {5'b01101, a, imm};               // LI
			1:  ins = {5'b01001, a, imm};               // ADDIU
			2:  ins = {5'b01000, a, b, 1'b0, imm[3:0]}; // ADDIU3
			3:  ins = {5'b01100, 3'b011, imm};          // ADDSP
			4:  ins = {5'b11100, a, b, c, 2'b01};       // ADDU
			5:  ins = {5'b11100, a, b, c, 2'b11};       // SUBU
			6:  ins = {5'b11101, a, b, 5'b01100};       // AND
			7:  ins = {5'b11101, a, b, 5'b01101};       // OR
			8:  ins = {5'b11101, a, b, 5'b01010};       // CMP
			9:  ins = {5'b00110, a, b, c, 2'b00};       // SLL
			10: ins = {5'b00110, a, b, c, 2'b10};       // SRL
			11: ins = {5'b00110, a, b, c, 2'b11};       // SRA
			12: ins = {5'b11101, a, b, 5'b00111};       // SRAV
			13: ins = {5'b01100, 3'b100, b, 5'b00000};  // MTSP
			14: ins = {5'b11110, a, 8'h01};             // MTIH
			15: ins = {5'b11110, a, 8'h00};             // MFIH
			16: ins = {5'b01111, a, b, 5'b00000};       // MOVE
			17: ins = {5'b11101, a, 8'h40};             // MFPC
			default: ins = 16'h0800;                    // NOP
		endcase
		return ins;
	endfunction

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////
	function automatic wb_t model_exec(input word_t ins, input word_t ipc);
		wb_t   r;
		word_t x;
		word_t y;
		word_t s8;
		int    amt;
		r       = '0;
		r.valid = 1'b1;
		r.dst   = {1'b0, ins[10:8]};
		x       = shadow[ins[10:8]];
		y       = shadow[ins[7:5]];
		s8      = {{8{ins[7]}}, ins[7:0]};
		amt     = (ins[4:2] == 3'd0) ? 8 : int'(ins[4:2]);  // Zero field shifts by 8
		case (ins[15:11])
			5'b01101: r.value = {8'h00, ins[7:0]};
			5'b01001: r.value = x + s8;
			5'b01000: begin
				r.dst   = {1'b0, ins[7:5]};
				r.value = x + {{12{ins[3]}}, ins[3:0]};
			end
			5'b01100: begin
				r.dst   = `REG_SP;
				r.value = (ins[10:8] == 3'b011) ? shadow[`REG_SP] + s8 : y;  // ADDSP or MTSP
			end
			5'b01111: r.value = y;
			5'b11100: begin
				r.dst   = {1'b0, ins[4:2]};
				r.value = ins[1] ? x - y : x + y;
			end
			5'b11101: begin
				case (ins[4:0])
					5'b01100: r.value = x & y;
					5'b01101: r.value = x | y;
					5'b01010: begin
						r.dst   = `REG_T;
						r.value = (x != y) ? 16'd1 : 16'd0;
					end
					5'b00111: begin
						r.dst   = {1'b0, ins[7:5]};
						r.value = word_t'($signed(y) >>> x[3:0]);
					end
					default: r.value = ipc + 16'd1;  // MFPC
				endcase
			end
			5'b11110: begin
				if (ins[0]) begin
					r.dst   = `REG_IH;
					r.value = x;
				end else begin
					r.value = shadow[`REG_IH];
				end
			end
			5'b00110: begin
				case (ins[1:0])
					2'b00:   r.value = y << amt;
					2'b10:   r.value = y >> amt;
					default: r.value = word_t'($signed(y) >>> amt);
				endcase
			end
			default: r.valid = 1'b0;  // NOP retires nothing
		endcase
		if (r.valid) shadow[r.dst] = r.value;
		return r;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
			$display("=== FAIL ===");
			$fatal(1, "Mismatch in %s", name);
		end
	endtask

	//////////////////////////////////////////////////
	// Driver
	//////////////////////////////////////////////////
	task automatic issue(input word_t ins, input logic use_hold, input logic drop);
		wb_t         exp;
		logic [31:0] r;
		r        = lcg_next();
		in.valid = 1'b1;
		in.instr = ins;
		in.pc    = pc;
		flush    = 1'b0;
		for (int i = 0; i < 3 && use_hold && r[24 + i * 2 +: 2] == 2'd0; i++) begin
			hold = 1'b1;  // Instruction stays on the input while held
			@(posedge clk);
			#2;
		end
		hold = 1'b0;
		if (!drop) begin
			exp = model_exec(ins, pc);
			if (exp.valid) begin
				exp_q.push_back(exp);
				due_q.push_back(adv_edges + 3);
			end
		end
		@(posedge clk);
		#2;
		pc = pc + 16'd1;
		if (drop) begin
			in.valid = 1'b0;
			flush    = 1'b1;  // Kills it on its way into the operand stage
			@(posedge clk);
			#2;
			flush = 1'b0;
		end
	endtask

	task automatic run_phase(input string name, input int count, input int lo, input int hi,
			input logic use_hold, input logic use_flush);
		logic [31:0] r;
		int          guard;
		test_name = name;
		for (int n = 0; n < count; n++) begin
			r = lcg_next();
			issue(make_instr(lo + int'(r[31:16]) % (hi - lo + 1)), use_hold,
				use_flush && r[15:12] == 4'd0);
		end
		in.valid = 1'b0;
		guard    = 0;
		while (exp_q.size() != 0 && guard < 20) begin
			@(posedge clk);
			#2;
			guard++;
		end
		if (exp_q.size() != 0) begin
			$display("Timeout in %s: %0d results never retired", name, exp_q.size());
			$display("=== FAIL ===");
			$fatal(1, "Drain timeout");
		end
	endtask

	//////////////////////////////////////////////////
	// Retirement compare
	//////////////////////////////////////////////////
	always @(negedge clk) begin
		if (!rst && !hold && wb.valid) begin  // Last look before this record is replaced
			if (exp_q.size() == 0) begin
				$display("Register %0d written with no instruction outstanding", wb.dst);
				$display("=== FAIL ===");
				$fatal(1, "Unexpected retirement");
			end else begin
				check_value({test_name, " dst"}, 32'(exp_q[0].dst), 32'(wb.dst));
				check_value({test_name, " value"}, 32'(exp_q[0].value), 32'(wb.value));
				check_value({test_name, " latency"}, due_q[0], adv_edges);
				void'(exp_q.pop_front());
				void'(due_q.pop_front());
			end
		end
	end

	initial begin
		rst   = 1'b1;
		hold  = 1'b0;
		flush = 1'b0;
		in    = '0;
		for (int i = 0; i < `REG_CNT; i++) begin
			shadow[i] = '0;
		end
		repeat (10) @(posedge clk);
		#2;
		rst = 1'b0;
		run_phase("immediates", 40, 0, 3, 1'b0, 1'b0);
		run_phase("register_ops", 80, 0, 12, 1'b0, 1'b0);
		run_phase("special_regs", 60, 13, 17, 1'b0, 1'b0);
		run_phase("forwarding", 300, 0, 18, 1'b0, 1'b0);
		run_phase("hold_flush", 300, 0, 18, 1'b1, 1'b1);
		test_name = "idle";
		for (int i = 0; i < 8; i++) begin  // Pipeline stays quiet once drained
			@(posedge clk);
			#2;
		end
		$display("=== PASS ===");
		$finish;
	end

endmodule
